//--- verilog/fpu_defines.svh
// opcode, width, depth, flag and NaN macros shared by the fpu rtl and its testbench.
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

`define fpu_op_w    4
`define fpu_tag_w   6
`define fpu_depth   4

`define fop_min_s   4'h1
`define fop_max_s   4'h2
`define fop_abs_s   4'h3
`define fop_neg_s   4'h4
`define fop_cps_s   4'h5
`define fop_cmp_s   4'h6
`define fop_min_d   4'h7
`define fop_max_d   4'h8
`define fop_abs_d   4'h9
`define fop_neg_d   4'ha
`define fop_cps_d   4'hb
`define fop_cmp_d   4'hc
`define fop_cmp_dh  4'hd

`define fpu_flag_lt 0
`define fpu_flag_eq 1
`define fpu_flag_gt 2
`define fpu_flag_un 3

`define fpu_qnan_s  32'h7fc0_0000
`define fpu_qnan_d  64'h7ff8_0000_0000_0000

`endif

//--- verilog/fpu_pkg.sv
// types for the fpu halves; a 64-bit operand word seen as two singles or one double.
package fpu_pkg;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } single_t;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] man;
  } double_t;

  // lane 1 is the upper 32 bits.
  typedef union packed {
    single_t [1:0] s;
    double_t       d;
  } simd_word_t;

endpackage

//--- verilog/fpu_compare.sv
// combinational IEEE ordering of two operand words, per single lane or as one double.
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_compare (
  input  logic                dbl,
  input  fpu_pkg::simd_word_t a,
  input  fpu_pkg::simd_word_t b,
  output logic [1:0]          lt_lane,
  output logic [1:0]          nan_a,
  output logic [1:0]          nan_b,
  output logic [3:0]          flags0
);

  logic [1:0] lt_s;
  logic [1:0] eq_s;
  logic [1:0] nan_as;
  logic [1:0] nan_bs;
  logic       lt_d;
  logic       eq_d;
  logic       nan_ad;
  logic       nan_bd;

  // sign-magnitude order, so minus zero lands below plus zero.
  function automatic logic ord_lt(input logic sa, input logic sb,
                                  input logic [62:0] ma, input logic [62:0] mb);
    logic r;
    if (sa != sb)
      r = sa;
    else if (sa)
      r = ma > mb;
    else
      r = ma < mb;
    return r;
  endfunction

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      nan_as[i] = (a.s[i].exp == 8'hff) && (a.s[i].man != '0);
      nan_bs[i] = (b.s[i].exp == 8'hff) && (b.s[i].man != '0);
      lt_s[i]   = ord_lt(a.s[i].sign, b.s[i].sign,
                         {32'd0, a.s[i].exp, a.s[i].man},
                         {32'd0, b.s[i].exp, b.s[i].man});
      eq_s[i]   = (a.s[i] == b.s[i]) ||
                  ({a.s[i].exp, a.s[i].man} == '0 && {b.s[i].exp, b.s[i].man} == '0);
    end
  end

  always_comb begin
    nan_ad = (a.d.exp == 11'h7ff) && (a.d.man != '0);
    nan_bd = (b.d.exp == 11'h7ff) && (b.d.man != '0);
    lt_d   = ord_lt(a.d.sign, b.d.sign, {a.d.exp, a.d.man}, {b.d.exp, b.d.man});
    eq_d   = (a.d == b.d) || ({a.d.exp, a.d.man} == '0 && {b.d.exp, b.d.man} == '0);
  end

  assign lt_lane = dbl ? {2{lt_d}} : lt_s;
  assign nan_a   = dbl ? {2{nan_ad}} : nan_as;
  assign nan_b   = dbl ? {2{nan_bd}} : nan_bs;

  always_comb begin
    logic sel_un;
    logic sel_eq;
    logic sel_lt;
    sel_un = dbl ? (nan_ad | nan_bd) : (nan_as[0] | nan_bs[0]);
    sel_eq = dbl ? eq_d : eq_s[0];
    sel_lt = dbl ? lt_d : lt_s[0];
    flags0 = '0;
    if (sel_un)
      flags0[`fpu_flag_un] = 1'b1; // any NaN is unordered only.
    else if (sel_eq)
      flags0[`fpu_flag_eq] = 1'b1;
    else if (sel_lt)
      flags0[`fpu_flag_lt] = 1'b1;
    else
      flags0[`fpu_flag_gt] = 1'b1;
  end

endmodule

//--- verilog/fpu_half.sv
// one 64-bit half of the four-stage min/max/sign/compare pipeline, used twice by fpu_both.
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_half (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic [`fpu_op_w-1:0]  op,
  input  logic [`fpu_tag_w-1:0] tag,
  input  logic [63:0]           a,
  input  logic [63:0]           b,
  output logic [63:0]           res,
  output logic [3:0]            flags,
  output logic [`fpu_tag_w-1:0] ret_tag,
  output logic                  ret_en
);

  localparam int k_min = 0;
  localparam int k_max = 1;
  localparam int k_abs = 2;
  localparam int k_neg = 3;
  localparam int k_cps = 4;
  localparam int k_cmp = 5;

  localparam logic [63:0] sign_s = 64'h8000_0000_8000_0000;
  localparam logic [63:0] sign_d = 64'h8000_0000_0000_0000;

  logic [5:0]            kind_in;
  logic [5:0]            kind1;
  logic [5:0]            kind2;
  logic                  dbl_in;
  logic                  dbl1;
  logic                  dbl2;
  fpu_pkg::simd_word_t   a1;
  fpu_pkg::simd_word_t   b1;
  logic [63:0]           a2;
  logic [63:0]           b2;
  logic                  en1;
  logic                  en2;
  logic                  en3;
  logic [`fpu_tag_w-1:0] tag1;
  logic [`fpu_tag_w-1:0] tag2;
  logic [`fpu_tag_w-1:0] tag3;
  logic [1:0]            lt_c;
  logic [1:0]            nan_a_c;
  logic [1:0]            nan_b_c;
  logic [3:0]            flags_c;
  logic [1:0]            lt2;
  logic [1:0]            nan_a2;
  logic [1:0]            nan_b2;
  logic [3:0]            flags2;
  logic [3:0]            flags3;
  logic [63:0]           mask2;
  logic [63:0]           res_c;
  logic [63:0]           res3;

  // min when want_max is low; a lone NaN yields the other operand.
  function automatic logic [63:0] pick(input logic want_max, input logic lt,
                                       input logic na, input logic nb,
                                       input logic [63:0] x, input logic [63:0] y,
                                       input logic [63:0] qnan);
    logic [63:0] r;
    if (na && nb)
      r = qnan;
    else if (na)
      r = y;
    else if (nb)
      r = x;
    else
      r = (lt ^ want_max) ? x : y;
    return r;
  endfunction

  assign dbl_in = (op == `fop_min_d) || (op == `fop_max_d) || (op == `fop_abs_d) ||
                  (op == `fop_neg_d) || (op == `fop_cps_d) || (op == `fop_cmp_d) ||
                  (op == `fop_cmp_dh);

  always_comb begin
    kind_in = '0;
    case (op)
      `fop_min_s, `fop_min_d:               kind_in[k_min] = 1'b1;
      `fop_max_s, `fop_max_d:               kind_in[k_max] = 1'b1;
      `fop_abs_s, `fop_abs_d:               kind_in[k_abs] = 1'b1;
      `fop_neg_s, `fop_neg_d:               kind_in[k_neg] = 1'b1;
      `fop_cps_s, `fop_cps_d:               kind_in[k_cps] = 1'b1;
      `fop_cmp_s, `fop_cmp_d, `fop_cmp_dh:  kind_in[k_cmp] = 1'b1;
      default:                              kind_in = '0; // unknown op gives zero.
    endcase
  end

  fpu_compare cmp_i (
    .dbl     (dbl1),
    .a       (a1),
    .b       (b1),
    .lt_lane (lt_c),
    .nan_a   (nan_a_c),
    .nan_b   (nan_b_c),
    .flags0  (flags_c)
  );

  always_comb begin
    logic [63:0] lane0;
    logic [63:0] lane1;
    logic [63:0] mm_d;
    logic [63:0] mm;
    lane0 = pick(kind2[k_max], lt2[0], nan_a2[0], nan_b2[0],
                 {32'd0, a2[31:0]}, {32'd0, b2[31:0]}, {32'd0, `fpu_qnan_s});
    lane1 = pick(kind2[k_max], lt2[1], nan_a2[1], nan_b2[1],
                 {32'd0, a2[63:32]}, {32'd0, b2[63:32]}, {32'd0, `fpu_qnan_s});
    mm_d  = pick(kind2[k_max], lt2[0], nan_a2[0], nan_b2[0], a2, b2, `fpu_qnan_d);
    mm    = dbl2 ? mm_d : {lane1[31:0], lane0[31:0]};
    mask2 = dbl2 ? sign_d : sign_s;
    res_c = '0; // compare leaves the data at zero.
    if (kind2[k_min] || kind2[k_max])
      res_c = mm;
    else if (kind2[k_abs])
      res_c = a2 & ~mask2;
    else if (kind2[k_neg])
      res_c = a2 ^ mask2;
    else if (kind2[k_cps])
      res_c = (a2 & ~mask2) | (b2 & mask2);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en1 <= 1'b0;
      en2 <= 1'b0;
      en3 <= 1'b0;
    end else begin
      en1 <= en;
      en2 <= en1;
      en3 <= en2;
    end
  end

  always_ff @(posedge clk) begin
    a1     <= a;
    b1     <= b;
    kind1  <= kind_in;
    dbl1   <= dbl_in;
    tag1   <= tag;
    a2     <= a1;
    b2     <= b1;
    kind2  <= kind1;
    dbl2   <= dbl1;
    tag2   <= tag1;
    lt2    <= lt_c;
    nan_a2 <= nan_a_c;
    nan_b2 <= nan_b_c;
    flags2 <= kind1[k_cmp] ? flags_c : 4'd0;
    res3   <= res_c;
    flags3 <= flags2;
    tag3   <= tag2;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_en  <= 1'b0;
      ret_tag <= '0;
      res     <= '0;
      flags   <= '0;
    end else begin
      ret_en  <= en3;
      ret_tag <= en3 ? tag3 : '0; // idle half drives zeros into the OR.
      res     <= en3 ? res3 : '0;
      flags   <= en3 ? flags3 : '0;
    end
  end

  a_ret_en_delay: assert property (@(posedge clk) disable iff (!rst_n)
    ret_en == $past(en, `fpu_depth))
    else $error("fpu_half: ret_en does not follow en by %0d cycles", `fpu_depth);

endmodule

//--- verilog/fpu_both.sv
// top of the dual-half fpu; merges the high and low returns and picks the compare flag source.
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_both (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [1:0]            en,
  input  logic [`fpu_op_w-1:0]  op,
  input  logic [`fpu_tag_w-1:0] tag,
  input  logic [63:0]           a_h,
  input  logic [63:0]           b_h,
  input  logic [63:0]           a_l,
  input  logic [63:0]           b_l,
  output logic [63:0]           res_h,
  output logic [63:0]           res_l,
  output logic [3:0]            flags,
  output logic [`fpu_tag_w-1:0] ret_tag,
  output logic                  ret_en
);

  logic [3:0]            flags_h;
  logic [3:0]            flags_l;
  logic [`fpu_tag_w-1:0] ret_tag_h;
  logic [`fpu_tag_w-1:0] ret_tag_l;
  logic                  ret_en_h;
  logic                  ret_en_l;
  logic [`fpu_op_w-1:0]  op_d [`fpu_depth];

  fpu_half half_h (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en[1]),
    .op      (op),
    .tag     (tag),
    .a       (a_h),
    .b       (b_h),
    .res     (res_h),
    .flags   (flags_h),
    .ret_tag (ret_tag_h),
    .ret_en  (ret_en_h)
  );

  fpu_half half_l (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en[0]),
    .op      (op),
    .tag     (tag),
    .a       (a_l),
    .b       (b_l),
    .res     (res_l),
    .flags   (flags_l),
    .ret_tag (ret_tag_l),
    .ret_en  (ret_en_l)
  );

  assign ret_tag = ret_tag_h | ret_tag_l; // idle half returns zeros.
  assign ret_en  = ret_en_h | ret_en_l;

  // op delay line, lines up with stage 4 of the halves.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `fpu_depth; i++) begin
        op_d[i] <= '0;
      end
    end else begin
      op_d[0] <= op;
      for (int i = 1; i < `fpu_depth; i++) begin
        op_d[i] <= op_d[i-1];
      end
    end
  end

  assign flags = (op_d[`fpu_depth-1] == `fop_cmp_dh) ? flags_h : flags_l;

  a_ret_tag_agree: assert property (@(posedge clk) disable iff (!rst_n)
    (ret_en_h && ret_en_l) |-> (ret_tag_h == ret_tag_l))
    else $error("fpu_both: halves returned tags %0h and %0h together", ret_tag_h, ret_tag_l);

endmodule

//--- testbench/fpu_model.svh
// reference model of the fpu half operations; included inside the fpu_both testbench.
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

function automatic logic [63:0] width_mask(input int w);
  return (w == 64) ? 64'hffff_ffff_ffff_ffff : 64'h0000_0000_ffff_ffff;
endfunction

function automatic bit nan_of(input logic [63:0] x, input int w);
  fpu_pkg::simd_word_t v;
  v = x;
  if (w == 64)
    return (v.d.exp == 11'h7ff) && (v.d.man != '0);
  return (v.s[0].exp == 8'hff) && (v.s[0].man != '0);
endfunction

// unsigned scale on which minus zero sits just below plus zero.
function automatic logic [63:0] order_key(input logic [63:0] x, input int w);
  logic [63:0] sb;
  sb = 64'd1 << (w - 1);
  if ((x & sb) != '0)
    return ~x & width_mask(w);
  return x | sb;
endfunction

function automatic logic [63:0] minmax_ref(input logic [63:0] x, input logic [63:0] y,
                                           input int w, input bit want_max);
  bit nx;
  bit ny;
  bit x_low;
  nx = nan_of(x, w);
  ny = nan_of(y, w);
  if (nx && ny)
    return (w == 64) ? `fpu_qnan_d : {32'd0, `fpu_qnan_s};
  if (nx)
    return y;
  if (ny)
    return x;
  x_low = order_key(x, w) < order_key(y, w);
  return (x_low != want_max) ? x : y;
endfunction

function automatic logic [3:0] flags_ref(input logic [63:0] x, input logic [63:0] y,
                                         input int w);
  logic [63:0] mag;
  mag = width_mask(w) >> 1;
  if (nan_of(x, w) || nan_of(y, w))
    return 4'd1 << `fpu_flag_un;
  if (x == y || ((x & mag) == '0 && (y & mag) == '0))
    return 4'd1 << `fpu_flag_eq; // signed zeros are equal.
  if (order_key(x, w) < order_key(y, w))
    return 4'd1 << `fpu_flag_lt;
  return 4'd1 << `fpu_flag_gt;
endfunction

function automatic logic [63:0] result_ref(input logic [3:0] op, input logic [63:0] a,
                                           input logic [63:0] b);
  fpu_pkg::simd_word_t va;
  fpu_pkg::simd_word_t vb;
  fpu_pkg::simd_word_t r;
  logic [63:0]         hi;
  logic [63:0]         lo;
  va = a;
  vb = b;
  r  = va;
  hi = minmax_ref({32'd0, a[63:32]}, {32'd0, b[63:32]}, 32, op == `fop_max_s);
  lo = minmax_ref({32'd0, a[31:0]}, {32'd0, b[31:0]}, 32, op == `fop_max_s);
  case (op)
    `fop_min_s, `fop_max_s: begin
      r.s[1] = hi[31:0];
      r.s[0] = lo[31:0];
    end
    `fop_abs_s: begin
      r.s[1].sign = 1'b0;
      r.s[0].sign = 1'b0;
    end
    `fop_neg_s: begin
      r.s[1].sign = ~va.s[1].sign;
      r.s[0].sign = ~va.s[0].sign;
    end
    `fop_cps_s: begin
      r.s[1].sign = vb.s[1].sign;
      r.s[0].sign = vb.s[0].sign;
    end
    `fop_min_d, `fop_max_d: r = minmax_ref(a, b, 64, op == `fop_max_d);
    `fop_abs_d: r.d.sign = 1'b0;
    `fop_neg_d: r.d.sign = ~va.d.sign;
    `fop_cps_d: r.d.sign = vb.d.sign;
    default: r = '0; // compares and unknown codes.
  endcase
  return r;
endfunction

function automatic logic [3:0] op_flags_ref(input logic [3:0] op, input logic [63:0] a,
                                            input logic [63:0] b);
  if (op == `fop_cmp_s)
    return flags_ref({32'd0, a[31:0]}, {32'd0, b[31:0]}, 32);
  if (op == `fop_cmp_d || op == `fop_cmp_dh)
    return flags_ref(a, b, 64);
  return 4'd0;
endfunction

`endif

//--- testbench/fpu_both_tb.sv
// testbench for fpu_both; directed and random ops are checked against the reference model.
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_both_tb;

  typedef struct packed {
    logic [31:0]           cyc;
    logic [`fpu_tag_w-1:0] tag;
    logic [63:0]           res_h;
    logic [63:0]           res_l;
    logic [3:0]            flags;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic [1:0]            en;
  logic [`fpu_op_w-1:0]  op;
  logic [`fpu_tag_w-1:0] tag;
  logic [63:0]           a_h;
  logic [63:0]           b_h;
  logic [63:0]           a_l;
  logic [63:0]           b_l;
  logic [63:0]           res_h;
  logic [63:0]           res_l;
  logic [3:0]            flags;
  logic [`fpu_tag_w-1:0] ret_tag;
  logic                  ret_en;

  expect_t               pend[$];
  string                 pend_name[$];
  string                 test_name;
  logic [`fpu_tag_w-1:0] tag_cnt = '0;
  int unsigned           cycle = 0;
  int                    seed = 32'hbb76_e401;
  int                    errors = 0;
  int                    err_start = 0;
  int                    checks = 0;
  int                    tests = 0;
  logic [3:0] sign_ops [6] = '{`fop_abs_s, `fop_neg_s, `fop_cps_s,
                               `fop_abs_d, `fop_neg_d, `fop_cps_d};
  logic [3:0] mm_ops [4] = '{`fop_min_s, `fop_max_s, `fop_min_d, `fop_max_d};
  logic [3:0] cmp_ops [3] = '{`fop_cmp_s, `fop_cmp_d, `fop_cmp_dh};

  `include "fpu_model.svh"

  fpu_both dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] rand_single();
    case ({$random(seed)} % 8)
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'h7f80_0000;
      3: return `fpu_qnan_s;
      4: return 32'hff80_0001; // signaling NaN.
      default: return $random(seed);
    endcase
  endfunction

  function automatic logic [63:0] rand_word(input bit dbl);
    if (!dbl)
      return {rand_single(), rand_single()};
    case ({$random(seed)} % 8)
      0: return 64'h0;
      1: return 64'h8000_0000_0000_0000;
      2: return 64'hfff0_0000_0000_0000;
      3: return `fpu_qnan_d;
      4: return 64'h7ff0_0000_0000_0001;
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  task automatic issue(input logic [1:0] e, input logic [3:0] o, input logic [63:0] ah,
                       input logic [63:0] bh, input logic [63:0] al, input logic [63:0] bl);
    expect_t x;
    @(posedge clk);
    #10;
    en      = e;
    op      = o;
    tag     = tag_cnt;
    a_h     = ah;
    b_h     = bh;
    a_l     = al;
    b_l     = bl;
    tag_cnt = tag_cnt + 1'b1;
    x.cyc   = cycle; // cycle in which the op is driven.
    x.tag   = tag;
    x.res_h = e[1] ? result_ref(o, ah, bh) : 64'd0;
    x.res_l = e[0] ? result_ref(o, al, bl) : 64'd0;
    if (o == `fop_cmp_dh)
      x.flags = e[1] ? op_flags_ref(o, ah, bh) : 4'd0;
    else
      x.flags = e[0] ? op_flags_ref(o, al, bl) : 4'd0;
    if (e != 2'b00) begin
      pend.push_back(x);
      pend_name.push_back(test_name);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = 0;
    @(posedge clk);
    #10 en = 2'b00;
    while (pend.size() > 0 && n < 4 * `fpu_depth) begin
      @(posedge clk);
      n++;
    end
    if (pend.size() > 0) begin
      $display("timed out with %0d returns still pending in %s", pend.size(), test_name);
      errors++;
      pend.delete();
      pend_name.delete();
    end
    tests++;
    $display("%s done, %0d errors", test_name, errors - err_start);
  endtask

  // compares each return with the oldest pending op.
  always @(negedge clk) begin
    expect_t x;
    string   nm;
    if (ret_en) begin
      if (pend.size() == 0) begin
        $display("unexpected return with tag %0h and nothing pending", ret_tag);
        errors++;
      end else begin
        x  = pend.pop_front();
        nm = pend_name.pop_front();
        checks++;
        assert (cycle - x.cyc == `fpu_depth) else begin
          $display("error %s latency expected %0d actual %0d", nm, `fpu_depth, cycle - x.cyc);
          errors++;
        end
        assert (ret_tag == x.tag) else begin
          $display("error %s ret_tag expected %h actual %h", nm, x.tag, ret_tag);
          errors++;
        end
        assert (res_h == x.res_h) else begin
          $display("error %s res_h expected %h actual %h", nm, x.res_h, res_h);
          errors++;
        end
        assert (res_l == x.res_l) else begin
          $display("error %s res_l expected %h actual %h", nm, x.res_l, res_l);
          errors++;
        end
        assert (flags == x.flags) else begin
          $display("error %s flags expected %b actual %b", nm, x.flags, flags);
          errors++;
        end
      end
    end else if (pend.size() > 0 && cycle > pend[0].cyc + `fpu_depth) begin
      $display("no return for tag %0h issued at cycle %0d", pend[0].tag, pend[0].cyc);
      errors++;
      void'(pend.pop_front());
      void'(pend_name.pop_front());
    end
  end

  initial begin
    logic [3:0] o;
    rst_n = 1'b0;
    en    = 2'b00;
    op    = '0;
    tag   = '0;
    a_h   = '0;
    b_h   = '0;
    a_l   = '0;
    b_l   = '0;
    repeat (2) @(posedge clk);
    #10 rst_n = 1'b1;

    start_test("reset and latency");
    assert (!ret_en && ret_tag == 0 && res_h == 0 && res_l == 0 && flags == 0) else begin
      $display("outputs are not all zero after reset");
      errors++;
    end
    issue(2'b11, `fop_neg_d, rand_word(1), rand_word(1), rand_word(1), rand_word(1));
    end_test();

    start_test("sign ops");
    for (int i = 0; i < 12; i++) begin
      o = sign_ops[i % 6];
      issue(2'b11, o, rand_word(i >= 6), rand_word(i >= 6), rand_word(i >= 6), rand_word(i >= 6));
    end
    end_test();

    start_test("min max");
    issue(2'b11, `fop_min_s, 64'h0000_0000_8000_0000, 64'h8000_0000_0000_0000,
          {`fpu_qnan_s, 32'h3f80_0000}, {32'h4000_0000, `fpu_qnan_s});
    issue(2'b11, `fop_max_s, {`fpu_qnan_s, 32'hbf80_0000}, {32'h7fa0_0000, 32'h8000_0000},
          64'h0000_0000_8000_0000, 64'h8000_0000_0000_0000);
    issue(2'b11, `fop_max_d, 64'h0, 64'h8000_0000_0000_0000, `fpu_qnan_d, 64'h7ff0_0000_0000_0001);
    issue(2'b11, `fop_min_d, `fpu_qnan_d, 64'hbff0_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h0);
    for (int i = 0; i < 16; i++) begin
      o = mm_ops[{$random(seed)} % 4];
      issue(2'b11, o, rand_word(o[3]), rand_word(o[3]), rand_word(o[3]), rand_word(o[3]));
    end
    end_test();

    start_test("compare");
    issue(2'b11, `fop_cmp_dh, 64'h3ff0_0000_0000_0000, 64'h4000_0000_0000_0000,
          64'h4000_0000_0000_0000, 64'h3ff0_0000_0000_0000); // high lt, low gt.
    issue(2'b11, `fop_cmp_d, 64'h3ff0_0000_0000_0000, 64'h4000_0000_0000_0000,
          64'h4000_0000_0000_0000, 64'h3ff0_0000_0000_0000);
    issue(2'b11, `fop_cmp_s, 64'h0, 64'h0, 64'h0000_0000_8000_0000, 64'h0);
    for (int i = 0; i < 16; i++) begin
      o = cmp_ops[{$random(seed)} % 3];
      issue(2'b11, o, rand_word(o[3]), rand_word(o[3]), rand_word(o[3]), rand_word(o[3]));
    end
    end_test();

    start_test("back to back");
    for (int i = 0; i < 32; i++) begin
      o = 4'($random(seed));
      issue(2'($random(seed)), o, rand_word(o[3]), rand_word(o[3]), rand_word(o[3]),
            rand_word(o[3]));
    end
    end_test();

    $display("%0d tests, %0d returns checked, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
+incdir+testbench
verilog/fpu_pkg.sv
verilog/fpu_compare.sv
verilog/fpu_half.sv
verilog/fpu_both.sv
testbench/fpu_both_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpu_both_tb -o fpu_sim \
  -f verilog.f \
  && ./obj_dir/fpu_sim > sim.log 2>&1 \
  || { echo "simulation did not build or run"; exit 1; }
cat sim.log
grep -q "^test passed$" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
